// ==== filelist.f ====
hdl/clkgen_pkg.sv
hdl/clkgen_ctrl_pkg.sv
hdl/clk_cfg_if.sv
hdl/rst_sync.sv
hdl/req_edge_sync.sv
hdl/div_cfg_ctrl.sv
hdl/clk_div_core.sv
hdl/clk_divider.sv
testbench/tb_clk_divider.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the clock divider testbench with Verilator
cd "$(dirname "$0")" && \
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f filelist.f --top-module tb_clk_divider -o tb_clk_divider && \
./obj_dir/tb_clk_divider || exit 1

// ==== testbench/tb_clk_divider.sv ====
`timescale 1ns/1ps

module tb_clk_divider import clkgen_pkg::*; ();

   localparam longint CLK_PERIOD = 100;
   localparam longint DRIVE_DLY = 5;
   localparam longint HS_CYCLES = 3;
   localparam longint NUM_PERIODS = 3;
   localparam int NUM_RAND = 12;
   localparam longint MAX_REQ = 24;
   localparam longint REQ_CYCLES_MAX = 4 + 2 * 15 + 4 * 15;
   localparam longint TIMEOUT_NS = (MAX_REQ * REQ_CYCLES_MAX * CLK_PERIOD * 4) / 3;

   logic       clk_i;
   logic       rstn_i;
   logic       test_mode_i;
   logic       clk_gate_async_i;
   div_ratio_t clk_div_data_i;
   logic       clk_div_valid_i;
   logic       clk_div_ack_o;
   logic       clk_o;

   logic [7:0] lfsr_q;
   bit         req_started;
   bit         gated_window;
   longint     last_rise_ns = 0;
   longint     prev_rise_ns = 0;
   longint     last_fall_ns = 0;
   longint     rise_cnt = 0;
   longint     fall_cnt = 0;

   clk_divider
   #(
      .DIV_INIT        (DIV_INIT_DEF),
      .BYPASS_INIT     (BYPASS_INIT_DEF),
      .RST_SYNC_STAGES (RST_SYNC_STAGES_DEF),
      .REQ_SYNC_STAGES (REQ_SYNC_STAGES_DEF)
   )
   clk_divider_i
   (
      .clk_i            (clk_i),
      .rstn_i           (rstn_i),
      .test_mode_i      (test_mode_i),
      .clk_gate_async_i (clk_gate_async_i),
      .clk_div_data_i   (clk_div_data_i),
      .clk_div_valid_i  (clk_div_valid_i),
      .clk_div_ack_o    (clk_div_ack_o),
      .clk_o            (clk_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial
   begin
      #TIMEOUT_NS;
      $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      stop_on_failure();
   end

   // ############################
   // output edge monitor
   // ############################

   always @(posedge clk_o)
   begin
      prev_rise_ns = last_rise_ns;
      last_rise_ns = $time;
      rise_cnt = rise_cnt + 1;
   end

   always @(negedge clk_o)
   begin
      last_fall_ns = $time;
      fall_cnt = fall_cnt + 1;
   end

   a_ack_idle: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      !req_started |-> !clk_div_ack_o
   ) else report_mismatch("ack_before_request", 0, 1);

   a_gate_low: assert property (
      @(posedge clk_i) gated_window |-> !clk_o
   ) else report_mismatch("gated_clk_low", 0, 1);

   task automatic stop_on_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped on the first error");
   endtask

   task automatic report_mismatch(string name, longint expected, longint actual);
      $display("ERR %s expected %0d actual %0d", name, expected, actual);
      stop_on_failure();
   endtask

   // galois form, x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_next(logic [7:0] s);
      if (s[0])
         return (s >> 1) ^ 8'hB8;
      else
         return s >> 1;
   endfunction

   task automatic draw_ratio(output longint ratio);
      ratio = 0;
      repeat (4)
      begin
         ratio = (ratio << 1) | longint'(lfsr_q[0]);
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   // full four-phase handshake, ack counted in input cycles
   task automatic request_ratio(longint ratio);
      longint cycles;
      @(posedge clk_i);
      #DRIVE_DLY;
      clk_div_data_i = div_ratio_t'(ratio);
      clk_div_valid_i = 1'b1;
      req_started = 1'b1;
      cycles = 0;
      while (!clk_div_ack_o)
      begin
         @(posedge clk_i);
         #DRIVE_DLY;
         cycles = cycles + 1;
      end
      assert (cycles == HS_CYCLES) else report_mismatch("ack_rise_cycles", HS_CYCLES, cycles);
      clk_div_valid_i = 1'b0;
      cycles = 0;
      while (clk_div_ack_o)
      begin
         @(posedge clk_i);
         #DRIVE_DLY;
         cycles = cycles + 1;
      end
      assert (cycles == HS_CYCLES) else report_mismatch("ack_fall_cycles", HS_CYCLES, cycles);
   endtask

   // first output period after a change is skipped
   task automatic measure_output(string name, longint n);
      longint exp_period;
      longint exp_high;
      exp_period = n * CLK_PERIOD;
      exp_high = (n * CLK_PERIOD) / 2;
      repeat (2) @(posedge clk_o);
      repeat (NUM_PERIODS)
      begin
         @(posedge clk_o);
         #1;
         assert (last_rise_ns - prev_rise_ns == exp_period)
            else report_mismatch({name, "_period"}, exp_period, last_rise_ns - prev_rise_ns);
         assert (last_fall_ns - prev_rise_ns == exp_high)
            else report_mismatch({name, "_high"}, exp_high, last_fall_ns - prev_rise_ns);
      end
   endtask

   task automatic check_gating(longint n);
      longint edges_before;
      @(posedge clk_i);
      #DRIVE_DLY;
      clk_gate_async_i = 1'b0;
      // two sync flops plus a pulse already in flight
      repeat (n + 4) @(posedge clk_i);
      #DRIVE_DLY;
      gated_window = 1'b1;
      edges_before = rise_cnt + fall_cnt;
      repeat (3 * n) @(posedge clk_i);
      #DRIVE_DLY;
      assert (rise_cnt + fall_cnt == edges_before)
         else report_mismatch("gated_clk_edges", edges_before, rise_cnt + fall_cnt);
      gated_window = 1'b0;
      clk_gate_async_i = 1'b1;
      measure_output("gate_resume", n);
   endtask

   // ############################
   // test sequence
   // ############################

   initial
   begin
      longint ratio;
      longint last_ratio;
      lfsr_q = 8'd73;
      rstn_i = 1'b0;
      test_mode_i = 1'b0;
      clk_gate_async_i = 1'b1;
      clk_div_data_i = '0;
      clk_div_valid_i = 1'b0;
      req_started = 1'b0;
      gated_window = 1'b0;
      last_ratio = 1;

      repeat (8) @(posedge clk_i);
      #DRIVE_DLY;
      rstn_i = 1'b1;
      repeat (8) @(posedge clk_i);
      #DRIVE_DLY;
      assert (clk_div_ack_o == 1'b0)
         else report_mismatch("ack_after_reset", 0, longint'(clk_div_ack_o));
      measure_output("reset_bypass", 1);

      for (int i = 0; i < NUM_RAND; i++)
      begin
         draw_ratio(ratio);
         request_ratio(ratio);
         if (ratio < 2)
            measure_output("lfsr_bypass", 1);
         else if (ratio % 2 == 0)
            measure_output("even_div", ratio);
         else
            measure_output("odd_div", ratio);
         last_ratio = ratio;
      end

      check_gating((last_ratio < 2) ? 1 : last_ratio);

      request_ratio(0);
      measure_output("bypass_ratio0", 1);
      request_ratio(1);
      measure_output("bypass_ratio1", 1);

      // divider keeps ratio 6 while test mode passes the input clock
      request_ratio(6);
      measure_output("even_div", 6);
      @(posedge clk_i);
      #DRIVE_DLY;
      test_mode_i = 1'b1;
      measure_output("test_mode", 1);
      @(posedge clk_i);
      #DRIVE_DLY;
      test_mode_i = 1'b0;

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== hdl/clk_divider.sv ====
`timescale 1ns/1ps

module clk_divider import clkgen_pkg::*;
#(
   parameter div_ratio_t  DIV_INIT        = DIV_INIT_DEF,
   parameter bit          BYPASS_INIT     = BYPASS_INIT_DEF,
   parameter int unsigned RST_SYNC_STAGES = RST_SYNC_STAGES_DEF,
   parameter int unsigned REQ_SYNC_STAGES = REQ_SYNC_STAGES_DEF
)
(
   input  logic       clk_i,
   input  logic       rstn_i,
   input  logic       test_mode_i,
   input  logic       clk_gate_async_i,
   input  div_ratio_t clk_div_data_i,
   input  logic       clk_div_valid_i,
   output logic       clk_div_ack_o,
   output logic       clk_o
);

   logic s_rstn_sync;

   clk_cfg_if cfg_if ();

   // ############################
   // reset
   // ############################

   rst_sync
   #(
      .NUM_REGS(RST_SYNC_STAGES)
   )
   i_rst_sync
   (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .test_mode_i   (test_mode_i),
      .s_rstn_sync_o (s_rstn_sync)
   );

   // ############################
   // control and divider
   // ############################

   div_cfg_ctrl
   #(
      .REQ_SYNC_STAGES(REQ_SYNC_STAGES)
   )
   i_cfg_ctrl
   (
      .clk_i            (clk_i),
      .s_rstn_sync      (s_rstn_sync),
      .test_mode_i      (test_mode_i),
      .clk_gate_async_i (clk_gate_async_i),
      .clk_div_data_i   (clk_div_data_i),
      .clk_div_valid_i  (clk_div_valid_i),
      .clk_div_ack_o    (clk_div_ack_o),
      .cfg              (cfg_if.ctrl)
   );

   clk_div_core
   #(
      .DIV_INIT    (DIV_INIT),
      .BYPASS_INIT (BYPASS_INIT)
   )
   i_div_core
   (
      .clk_i       (clk_i),
      .s_rstn_sync (s_rstn_sync),
      .cfg         (cfg_if.core),
      .clk_o       (clk_o)
   );

endmodule

// ==== hdl/clk_div_core.sv ====
`timescale 1ns/1ps

module clk_div_core import clkgen_pkg::*;
#(
   parameter div_ratio_t DIV_INIT    = DIV_INIT_DEF,
   parameter bit         BYPASS_INIT = BYPASS_INIT_DEF
)
(
   input  logic    clk_i,
   input  logic    s_rstn_sync,
   clk_cfg_if.core cfg,
   output logic    clk_o
);

   // wrap value of the counter for a ratio
   function automatic div_ratio_t term_count(div_ratio_t n);
      if (n <= DIV_BYPASS_MAX)
         return '0;
      else if (n[0])
         return n - div_ratio_t'(1);
      else if (n == div_ratio_t'(2))
         return '0;
      else
         return (n >> 1) - div_ratio_t'(1);
   endfunction

   localparam div_ratio_t TERM_INIT = term_count(DIV_INIT);
   localparam bit ODD_INIT = DIV_INIT[0] && (DIV_INIT > DIV_BYPASS_MAX);

   div_ratio_t cnt_q;
   div_ratio_t term_q;
   div_ratio_t half_cnt;
   logic       bypass_q;
   logic       odd_q;
   logic       div1_q;
   logic       div2_q;
   logic       load_bypass;
   logic       rise_en;
   logic       fall_en;
   logic       clk_gen;
   logic       clk_src;
   logic       gate_en_l;

   assign load_bypass = (cfg.ratio <= DIV_BYPASS_MAX);

   // falling toggle sits half a count after the rising one
   assign half_cnt = (term_q >> 1) + div_ratio_t'(1);
   assign rise_en  = !bypass_q && (cnt_q == '0);
   assign fall_en  = odd_q && !bypass_q && (cnt_q == half_cnt);

   // ############################
   // counter and rising toggle
   // ############################

   always_ff @(posedge clk_i or negedge s_rstn_sync)
   begin
      if (!s_rstn_sync)
      begin
         cnt_q    <= '0;
         term_q   <= TERM_INIT;
         bypass_q <= BYPASS_INIT;
         odd_q    <= ODD_INIT;
         div1_q   <= 1'b0;
      end
      else if (cfg.load)
      begin
         cnt_q    <= '0;
         term_q   <= term_count(cfg.ratio);
         bypass_q <= load_bypass;
         odd_q    <= cfg.ratio[0] && !load_bypass;
         div1_q   <= 1'b0;
      end
      else
      begin
         if (!bypass_q)
            cnt_q <= (cnt_q == term_q) ? '0 : cnt_q + div_ratio_t'(1);
         if (rise_en)
            div1_q <= ~div1_q;
      end
   end

   // odd ratios only
   always_ff @(negedge clk_i or negedge s_rstn_sync)
   begin
      if (!s_rstn_sync)
         div2_q <= 1'b0;
      else if (cfg.load)
         div2_q <= 1'b0;
      else if (fall_en)
         div2_q <= ~div2_q;
   end

   // ############################
   // clock path
   // ############################

   assign clk_gen = div1_q ^ div2_q;
   assign clk_src = (bypass_q || cfg.test_mode) ? clk_i : clk_gen;

   // open while the source is low, so a started pulse always completes
   always_latch
   begin
      if (!s_rstn_sync)
         gate_en_l <= 1'b0;
      else if (!clk_src)
         gate_en_l <= cfg.clk_en || cfg.test_mode;
   end

   assign clk_o = clk_src & gate_en_l;

   a_cnt_in_range: assert property (
      @(posedge clk_i) disable iff (!s_rstn_sync)
      !bypass_q |-> (cnt_q <= term_q)
   );

endmodule

// ==== hdl/div_cfg_ctrl.sv ====
`timescale 1ns/1ps

module div_cfg_ctrl import clkgen_pkg::*, clkgen_ctrl_pkg::*;
#(
   parameter int unsigned REQ_SYNC_STAGES = REQ_SYNC_STAGES_DEF
)
(
   input  logic       clk_i,
   input  logic       s_rstn_sync,
   input  logic       test_mode_i,
   input  logic       clk_gate_async_i,
   input  div_ratio_t clk_div_data_i,
   input  logic       clk_div_valid_i,
   output logic       clk_div_ack_o,
   clk_cfg_if.ctrl    cfg
);

   cfg_state_e state_q;
   cfg_state_e state_d;
   div_ratio_t ratio_q;
   logic [1:0] gate_sync_q;
   logic       req_edge;

   // valid level in, ack level and one-cycle edge out
   req_edge_sync
   #(
      .STAGES(REQ_SYNC_STAGES)
   )
   i_req_sync
   (
      .clk_i       (clk_i),
      .s_rstn_sync (s_rstn_sync),
      .serial_i    (clk_div_valid_i),
      .serial_o    (clk_div_ack_o),
      .r_edge_o    (req_edge)
   );

   // ############################
   // reload sequence
   // ############################

   always_comb
   begin
      case (state_q)
         CFG_IDLE:
            state_d = req_edge ? CFG_STOP : CFG_IDLE;
         CFG_STOP:
            state_d = CFG_WAIT;
         CFG_WAIT:
            state_d = CFG_RELEASE;
         default:
            state_d = CFG_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge s_rstn_sync)
   begin
      if (!s_rstn_sync)
         state_q <= CFG_IDLE;
      else
         state_q <= state_d;
   end

   // data is stable by protocol when the edge shows up
   always_ff @(posedge clk_i or negedge s_rstn_sync)
   begin
      if (!s_rstn_sync)
         ratio_q <= DIV_INIT_DEF;
      else if (req_edge)
         ratio_q <= clk_div_data_i;
   end

   // gate enable crosses in through two flops
   always_ff @(posedge clk_i or negedge s_rstn_sync)
   begin
      if (!s_rstn_sync)
         gate_sync_q <= 2'b00;
      else
         gate_sync_q <= {gate_sync_q[0], clk_gate_async_i};
   end

   assign cfg.ratio     = ratio_q;
   assign cfg.load      = (state_q == CFG_STOP);
   assign cfg.clk_en    = cfg_clk_running(state_q) & gate_sync_q[1];
   assign cfg.test_mode = test_mode_i;

   // ############################
   // checks
   // ############################

   a_load_in_stop: assert property (
      @(posedge clk_i) disable iff (!s_rstn_sync)
      cfg.load |-> (state_q == CFG_STOP)
   );

   a_clk_off_on_load: assert property (
      @(posedge clk_i) disable iff (!s_rstn_sync)
      cfg.load |-> !cfg.clk_en
   );

   a_reload_steps: assert property (
      @(posedge clk_i) disable iff (!s_rstn_sync)
      (state_q == CFG_STOP) |=> (state_q == CFG_WAIT)
         ##1 (state_q == CFG_RELEASE) ##1 (state_q == CFG_IDLE)
   );

endmodule

// ==== hdl/req_edge_sync.sv ====
`timescale 1ns/1ps

module req_edge_sync import clkgen_pkg::*;
#(
   parameter int unsigned STAGES = REQ_SYNC_STAGES_DEF
)
(
   input  logic clk_i,
   input  logic s_rstn_sync,
   input  logic serial_i,
   output logic serial_o,
   output logic r_edge_o
);

   logic [STAGES-1:0] sync_q;
   logic              serial_s;
   logic              serial_q;

   // synchronizer chain plus one delay flop for the edge
   always_ff @(posedge clk_i or negedge s_rstn_sync)
   begin
      if (!s_rstn_sync)
      begin
         sync_q   <= '0;
         serial_q <= 1'b0;
      end
      else
      begin
         sync_q   <= {sync_q[STAGES-2:0], serial_i};
         serial_q <= serial_s;
      end
   end

   assign serial_s = sync_q[STAGES-1];

   // delayed level doubles as the acknowledge
   assign serial_o = serial_q;
   assign r_edge_o = serial_s & ~serial_q;

   a_edge_single_cycle: assert property (
      @(posedge clk_i) disable iff (!s_rstn_sync)
      r_edge_o |=> !r_edge_o
   );

endmodule

// ==== hdl/rst_sync.sv ====
`timescale 1ns/1ps

module rst_sync import clkgen_pkg::*;
#(
   parameter int unsigned NUM_REGS = RST_SYNC_STAGES_DEF
)
(
   input  logic clk_i,
   input  logic rstn_i,
   input  logic test_mode_i,
   output logic s_rstn_sync_o
);

   logic [NUM_REGS-1:0] sync_q;

   // clears at once, fills with ones after release
   always_ff @(posedge clk_i or negedge rstn_i)
   begin
      if (!rstn_i)
      begin
         sync_q <= '0;
      end
      else
      begin
         sync_q <= {sync_q[NUM_REGS-2:0], 1'b1};
      end
   end

   // raw pad reset in test mode
   assign s_rstn_sync_o = test_mode_i ? rstn_i : sync_q[NUM_REGS-1];

   // ############################
   // elaboration check
   // ############################

   if (NUM_REGS < 2)
   begin : g_num_regs_check
      $error("rst_sync: NUM_REGS must be at least 2");
   end

endmodule

// ==== hdl/clk_cfg_if.sv ====
`timescale 1ns/1ps

interface clk_cfg_if import clkgen_pkg::*; ();

   // ratio is only sampled by the core while load is high
   div_ratio_t ratio;
   logic       load;
   logic       clk_en;
   logic       test_mode;

   modport ctrl
   (
      output ratio,
      output load,
      output clk_en,
      output test_mode
   );

   modport core
   (
      input ratio,
      input load,
      input clk_en,
      input test_mode
   );

endinterface

// ==== hdl/clkgen_ctrl_pkg.sv ====
package clkgen_ctrl_pkg;

   // reconfiguration sequence, one cycle per step after IDLE
   typedef enum logic [1:0]
   {
      CFG_IDLE    = 2'd0,
      CFG_STOP    = 2'd1,
      CFG_WAIT    = 2'd2,
      CFG_RELEASE = 2'd3
   } cfg_state_e;

   // output clock only runs outside the reload sequence
   function automatic logic cfg_clk_running(cfg_state_e state);
      return (state == CFG_IDLE);
   endfunction

endpackage

// ==== hdl/clkgen_pkg.sv ====
package clkgen_pkg;

   // ############################
   // ratio encoding
   // ############################

   localparam int DIV_RATIO_W = 8;

   typedef logic [DIV_RATIO_W-1:0] div_ratio_t;

   // ratios up to this value pass the input clock
   localparam div_ratio_t DIV_BYPASS_MAX = div_ratio_t'(1);

   // ############################
   // defaults
   // ############################

   localparam div_ratio_t DIV_INIT_DEF = div_ratio_t'(0);
   localparam bit BYPASS_INIT_DEF = 1'b1;

   // reset release after this many input edges
   localparam int unsigned RST_SYNC_STAGES_DEF = 4;

   // flops in front of the request edge detector
   localparam int unsigned REQ_SYNC_STAGES_DEF = 2;

endpackage
